/* design/calendar_config.svh */
`ifndef CALENDAR_CONFIG_SVH
`define CALENDAR_CONFIG_SVH

//////////////////////////////
// second tick divider
//////////////////////////////

// cycles per tick at the slow rate
`define CAL_DIV_SLOW 1000
// cycles per tick at the fast rate
`define CAL_DIV_FAST 10

// cycles each display digit stays lit
`define CAL_SCAN_DIV 4

//////////////////////////////
// reset date 2000-01-01 00:00:00, year digits
//////////////////////////////
`define CAL_RESET_YEAR_THOU 2
`define CAL_RESET_YEAR_HUND 0
`define CAL_RESET_YEAR_TENS 0
`define CAL_RESET_YEAR_UNIT 0

`endif

/* design/calendar_pkg.sv */
package calendar_pkg;

	typedef logic [3:0] bcd_t; // one decimal digit

	// full calendar time, 14 bcd digits
	typedef struct packed {
		bcd_t sec_unit;
		bcd_t sec_tens;
		bcd_t min_unit;
		bcd_t min_tens;
		bcd_t hour_unit;
		bcd_t hour_tens;
		bcd_t day_unit;
		bcd_t day_tens;
		bcd_t month_unit;
		bcd_t month_tens;
		bcd_t year_unit;
		bcd_t year_tens;
		bcd_t year_hund;
		bcd_t year_thou;
	} date_time_t;

	typedef struct packed {
		date_time_t date; // held stable until ack
		logic       req; // four-phase request
	} set_date_t;

	typedef enum logic [1:0] {
		RATE_SLOW = 2'd0, // every CAL_DIV_SLOW cycles
		RATE_FAST = 2'd1, // every CAL_DIV_FAST cycles
		RATE_FULL = 2'd2 // every cycle
	} rate_t;

	typedef enum logic [1:0] {
		VIEW_HHMM = 2'd0,
		VIEW_MMSS = 2'd1,
		VIEW_MMDD = 2'd2,
		VIEW_YYYY = 2'd3
	} view_t;

	typedef logic [14:0] ssd_t; // segments, active high
	typedef logic [3:0] scan_t; // one-hot digit enable

endpackage

/* design/tick_gen.sv */
`timescale 1ns/1ps
`include "calendar_config.svh"

module tick_gen (
	input  logic                clk,
	input  logic                reset,
	input  calendar_pkg::rate_t rate,
	output logic                tick
);

	localparam int CW = $clog2(`CAL_DIV_SLOW); // sized for longest period

	logic [CW-1:0] count; // cycles into current period
	logic [CW-1:0] last; // final count of a period
	calendar_pkg::rate_t rate_q; // rate of previous cycle

	always_comb begin
		case (rate)
			calendar_pkg::RATE_SLOW: last = CW'(`CAL_DIV_SLOW - 1);
			calendar_pkg::RATE_FAST: last = CW'(`CAL_DIV_FAST - 1);
			default:                 last = '0; // full rate
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count  <= '0;
			rate_q <= rate; // no restart right after reset
			tick   <= 1'b0;
		end else if (rate != rate_q) begin
			count  <= '0; // new rate, count from scratch
			rate_q <= rate;
			tick   <= 1'b0;
		end else if (count == last) begin
			count <= '0;
			tick  <= 1'b1; // one period done
		end else begin
			count <= count + 1'b1;
			tick  <= 1'b0;
		end
	end

endmodule

/* design/date_loader.sv */
`timescale 1ns/1ps

module date_loader (
	input  logic                     clk,
	input  logic                     reset,
	input  calendar_pkg::set_date_t  set_in,
	output logic                     set_ack,
	output logic                     load,
	output calendar_pkg::date_time_t load_date
);

	typedef enum logic [1:0] {
		IDLE    = 2'd0, // waiting for req
		LOADING = 2'd1, // counters take load_date
		ACKED   = 2'd2 // ack high until req drops
	} state_t;

	state_t state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (set_in.req)
						state <= LOADING;
				end
				LOADING: state <= ACKED; // single load cycle
				ACKED: begin
					if (!set_in.req)
						state <= IDLE; // handshake closed
				end
				default: state <= IDLE;
			endcase
		end
	end

	// capture on accept, date only needs to hold until ack
	always_ff @(posedge clk) begin
		if (state == IDLE && set_in.req)
			load_date <= set_in.date;
	end

	assign load    = (state == LOADING);
	assign set_ack = (state == ACKED);

endmodule

/* design/bcd_counter.sv */
`timescale 1ns/1ps

module bcd_counter #(
	parameter int DIGITS = 2 // 2 for sec..month, 4 for year
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            increase,
	input  logic                            load,
	input  calendar_pkg::bcd_t [DIGITS-1:0] load_value,
	input  calendar_pkg::bcd_t [DIGITS-1:0] def_value,
	input  calendar_pkg::bcd_t [DIGITS-1:0] limit,
	output calendar_pkg::bcd_t [DIGITS-1:0] value,
	output logic                            carry
);

	calendar_pkg::bcd_t [DIGITS-1:0] next_value; // value plus one
	logic at_limit;

	// bcd orders like binary, so a plain compare works
	// a loaded value past the limit also wraps
	assign at_limit = (value >= limit);
	assign carry    = increase & at_limit;

	//////////////////////////////
	// digit ripple increment
	//////////////////////////////
	always_comb begin
		logic ripple;
		ripple     = 1'b1; // add one at the unit digit
		next_value = value;
		for (int i = 0; i < DIGITS; i++) begin
			if (ripple) begin
				if (value[i] >= 4'd9) begin
					next_value[i] = 4'd0; // digit rolls, carry on
				end else begin
					next_value[i] = value[i] + 4'd1;
					ripple        = 1'b0; // stop here
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			value <= def_value;
		else if (load)
			value <= load_value; // load wins over increase
		else if (increase)
			value <= at_limit ? def_value : next_value;
	end

endmodule

/* design/month_length.sv */
`timescale 1ns/1ps

module month_length (
	input  calendar_pkg::bcd_t [1:0] month,
	input  calendar_pkg::bcd_t [3:0] year,
	output calendar_pkg::bcd_t [1:0] day_limit
);

	// two bcd digits divisible by 4
	// 10*t + u = 2*t + u mod 4, so parity of tens decides
	function automatic logic div4(input calendar_pkg::bcd_t tens, input calendar_pkg::bcd_t unit);
		if (tens[0])
			return (unit == 4'd2) || (unit == 4'd6);
		else
			return (unit == 4'd0) || (unit == 4'd4) || (unit == 4'd8);
	endfunction

	logic [7:0] month_code; // month as packed bcd pair
	logic       century; // year ends in 00
	logic       leap;

	assign month_code = {month[1], month[0]};
	assign century    = (year[1] == 4'd0) && (year[0] == 4'd0);
	// centuries leap only when hund/thou divide by 4
	assign leap = div4(year[1], year[0]) && (!century || div4(year[3], year[2]));

	always_comb begin
		case (month_code)
			8'h02:                      day_limit = leap ? 8'h29 : 8'h28;
			8'h04, 8'h06, 8'h09, 8'h11: day_limit = 8'h30;
			default:                    day_limit = 8'h31; // also invalid months
		endcase
	end

endmodule

/* design/calendar_core.sv */
`timescale 1ns/1ps
`include "calendar_config.svh"

module calendar_core (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     tick,
	input  logic                     load,
	input  calendar_pkg::date_time_t load_date,
	output calendar_pkg::date_time_t now
);

	calendar_pkg::bcd_t [1:0] secs, mins, hours, days, months; // [1] tens, [0] unit
	calendar_pkg::bcd_t [3:0] years;
	calendar_pkg::bcd_t [1:0] day_limit; // last day of current month
	calendar_pkg::bcd_t [3:0] year_def;
	logic step; // tick not eaten by a load
	logic carry_sec, carry_min, carry_hour, carry_day, carry_month;

	assign step = tick & ~load;
	// year starts at the reset date but wraps 9999 to 0000
	assign year_def = reset ? {calendar_pkg::bcd_t'(`CAL_RESET_YEAR_THOU),
		calendar_pkg::bcd_t'(`CAL_RESET_YEAR_HUND), calendar_pkg::bcd_t'(`CAL_RESET_YEAR_TENS),
		calendar_pkg::bcd_t'(`CAL_RESET_YEAR_UNIT)} : 16'h0000;

	//////////////////////////////
	// counter chain
	//////////////////////////////
	bcd_counter #(.DIGITS(2)) u_sec (.clk(clk), .reset(reset), .increase(step), .load(load),
		.load_value({load_date.sec_tens, load_date.sec_unit}),
		.def_value(8'h00), .limit(8'h59), .value(secs), .carry(carry_sec));
	bcd_counter #(.DIGITS(2)) u_min (.clk(clk), .reset(reset), .increase(carry_sec), .load(load),
		.load_value({load_date.min_tens, load_date.min_unit}),
		.def_value(8'h00), .limit(8'h59), .value(mins), .carry(carry_min));
	bcd_counter #(.DIGITS(2)) u_hour (.clk(clk), .reset(reset), .increase(carry_min), .load(load),
		.load_value({load_date.hour_tens, load_date.hour_unit}),
		.def_value(8'h00), .limit(8'h23), .value(hours), .carry(carry_hour));
	bcd_counter #(.DIGITS(2)) u_day (.clk(clk), .reset(reset), .increase(carry_hour), .load(load),
		.load_value({load_date.day_tens, load_date.day_unit}),
		.def_value(8'h01), .limit(day_limit), .value(days), .carry(carry_day)); // 28..31
	bcd_counter #(.DIGITS(2)) u_month (.clk(clk), .reset(reset), .increase(carry_day), .load(load),
		.load_value({load_date.month_tens, load_date.month_unit}),
		.def_value(8'h01), .limit(8'h12), .value(months), .carry(carry_month));
	bcd_counter #(.DIGITS(4)) u_year (.clk(clk), .reset(reset), .increase(carry_month), .load(load),
		.load_value({load_date.year_thou, load_date.year_hund, load_date.year_tens,
			load_date.year_unit}),
		.def_value(year_def), .limit(16'h9999), .value(years), .carry()); // top of chain

	month_length u_month_length (.month(months), .year(years), .day_limit(day_limit));

	// struct order, sec_unit in the top bits
	assign now = {secs[0], secs[1], mins[0], mins[1], hours[0], hours[1],
		days[0], days[1], months[0], months[1], years[0], years[1], years[2], years[3]};

endmodule

/* design/display_scan.sv */
`timescale 1ns/1ps
`include "calendar_config.svh"

module display_scan (
	input  logic                     clk,
	input  logic                     reset,
	input  calendar_pkg::view_t      view,
	input  calendar_pkg::date_time_t now,
	output calendar_pkg::ssd_t       seg,
	output calendar_pkg::scan_t      digit_en
);

	localparam int SW = $clog2(`CAL_SCAN_DIV + 1);

	logic [SW-1:0] scan_count; // cycles on current digit
	logic [1:0] index; // lit digit, 0 rightmost
	calendar_pkg::bcd_t [3:0] digits; // the four shown digits
	calendar_pkg::bcd_t digit; // digit under the scan

	//////////////////////////////
	// scan
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			scan_count <= '0;
			index      <= 2'd0;
		end else if (scan_count == SW'(`CAL_SCAN_DIV - 1)) begin
			scan_count <= '0;
			index      <= index + 2'd1; // next digit, wraps 3 to 0
		end else begin
			scan_count <= scan_count + 1'b1;
		end
	end

	assign digit_en = calendar_pkg::scan_t'(4'b0001 << index);

	always_comb begin
		case (view)
			calendar_pkg::VIEW_HHMM: digits = {now.hour_tens, now.hour_unit, now.min_tens, now.min_unit};
			calendar_pkg::VIEW_MMSS: digits = {now.min_tens, now.min_unit, now.sec_tens, now.sec_unit};
			calendar_pkg::VIEW_MMDD: digits = {now.month_tens, now.month_unit, now.day_tens,
				now.day_unit};
			default: digits = {now.year_thou, now.year_hund, now.year_tens, now.year_unit};
		endcase
	end

	assign digit = digits[index];

	//////////////////////////////
	// segment decode
	//////////////////////////////
	// bit 0..5 = a..f, 6/7 = middle halves g1/g2
	always_comb begin
		case (digit)
			4'd0:    seg = 15'h003F;
			4'd1:    seg = 15'h0006;
			4'd2:    seg = 15'h00DB;
			4'd3:    seg = 15'h00CF;
			4'd4:    seg = 15'h00E6;
			4'd5:    seg = 15'h00ED;
			4'd6:    seg = 15'h00FD;
			4'd7:    seg = 15'h0007;
			4'd8:    seg = 15'h00FF;
			4'd9:    seg = 15'h00EF;
			default: seg = 15'h0000; // not bcd, blank
		endcase
	end

endmodule

/* design/calendar_top.sv */
`timescale 1ns/1ps

module calendar_top (
	input  logic                     clk,
	input  logic                     reset,
	input  calendar_pkg::rate_t      rate,
	input  calendar_pkg::view_t      view,
	input  calendar_pkg::set_date_t  set_in,
	output logic                     set_ack,
	output calendar_pkg::date_time_t now,
	output calendar_pkg::ssd_t       seg,
	output calendar_pkg::scan_t      digit_en
);

	logic tick; // one second step
	logic load; // one cycle date load
	calendar_pkg::date_time_t load_date;

	//////////////////////////////
	// input side
	//////////////////////////////
	tick_gen u_tick_gen (
		.clk(clk), .reset(reset), .rate(rate), // speed select
		.tick(tick)
	);

	date_loader u_date_loader (
		.clk(clk), .reset(reset), .set_in(set_in), // req/ack slave
		.set_ack(set_ack), .load(load), .load_date(load_date)
	);

	// counters and month length
	calendar_core u_core (
		.clk(clk), .reset(reset), .tick(tick), .load(load),
		.load_date(load_date), .now(now)
	);

	//////////////////////////////
	// output side
	//////////////////////////////
	display_scan u_display (
		.clk(clk), .reset(reset), .view(view), .now(now),
		.seg(seg), .digit_en(digit_en)
	);

endmodule

/* tb/calendar_tb.sv */
`timescale 1ns/1ps
`include "calendar_config.svh"

module calendar_tb;

	localparam int TRACK_OFF  = 0; // monitor idle
	localparam int TRACK_HOLD = 1; // now must stay put
	localparam int TRACK_STEP = 2; // now gains one second per cycle
	// reset, rate run, rollovers, random runs, display, with margin
	localparam int LIMIT = 6 * (10 + 21 * `CAL_DIV_FAST + 6 * 12 + 40 * 56 + 4 * 24);

	logic clk;
	logic reset;
	calendar_pkg::rate_t      rate;
	calendar_pkg::view_t      view;
	calendar_pkg::set_date_t  set_in;
	logic                     set_ack;
	calendar_pkg::date_time_t now;
	calendar_pkg::ssd_t       seg;
	calendar_pkg::scan_t      digit_en;

	calendar_pkg::date_time_t expected; // model of now
	int          track_mode = TRACK_OFF;
	string       track_name = "idle";
	int          cycles = 0;
	logic [31:0] lfsr = 32'h0b9591b6;
	// bit 0..5 = a..f, 6/7 = middle halves
	calendar_pkg::ssd_t seg_table [0:9] = '{15'h003F, 15'h0006, 15'h00DB, 15'h00CF,
		15'h00E6, 15'h00ED, 15'h00FD, 15'h0007, 15'h00FF, 15'h00EF};

	calendar_top DUT (.clk(clk), .reset(reset), .rate(rate), .view(view), .set_in(set_in),
		.set_ack(set_ack), .now(now), .seg(seg), .digit_en(digit_en));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////
	// reference model
	//////////////////////////////
	function automatic int last_day(input int mo, input int y);
		case (mo)
			2:             return ((y % 4 == 0 && y % 100 != 0) || y % 400 == 0) ? 29 : 28;
			4, 6, 9, 11:   return 30;
			default:       return 31;
		endcase
	endfunction

	function automatic calendar_pkg::date_time_t make_date(input int y, input int mo,
		input int dy, input int h, input int mi, input int s);
		// struct order, sec_unit first
		return {4'(s % 10), 4'(s / 10), 4'(mi % 10), 4'(mi / 10), 4'(h % 10), 4'(h / 10),
			4'(dy % 10), 4'(dy / 10), 4'(mo % 10), 4'(mo / 10), 4'(y % 10), 4'(y / 10 % 10),
			4'(y / 100 % 10), 4'(y / 1000)};
	endfunction

	function automatic int two(input calendar_pkg::bcd_t tens, input calendar_pkg::bcd_t unit);
		return tens * 10 + unit;
	endfunction

	function automatic calendar_pkg::date_time_t next_second(input calendar_pkg::date_time_t d);
		int s, mi, h, dy, mo, y;
		s  = two(d.sec_tens, d.sec_unit);
		mi = two(d.min_tens, d.min_unit);
		h  = two(d.hour_tens, d.hour_unit);
		dy = two(d.day_tens, d.day_unit);
		mo = two(d.month_tens, d.month_unit);
		y  = two(d.year_thou, d.year_hund) * 100 + two(d.year_tens, d.year_unit);
		s = (s + 1) % 60;
		if (s == 0)
			mi = (mi + 1) % 60;
		if (s == 0 && mi == 0)
			h = (h + 1) % 24;
		if (s == 0 && mi == 0 && h == 0)
			dy = (dy >= last_day(mo, y)) ? 1 : dy + 1; // past the limit wraps too
		if (s == 0 && mi == 0 && h == 0 && dy == 1)
			mo = (mo >= 12) ? 1 : mo + 1;
		if (s == 0 && mi == 0 && h == 0 && dy == 1 && mo == 1)
			y = (y + 1) % 10000; // 9999 back to 0000
		return make_date(y, mo, dy, h, mi, s);
	endfunction

	function automatic calendar_pkg::bcd_t view_digit(input calendar_pkg::date_time_t d,
		input calendar_pkg::view_t v, input int idx);
		calendar_pkg::bcd_t pick [4]; // rightmost first
		case (v)
			calendar_pkg::VIEW_HHMM: pick = '{d.min_unit, d.min_tens, d.hour_unit, d.hour_tens};
			calendar_pkg::VIEW_MMSS: pick = '{d.sec_unit, d.sec_tens, d.min_unit, d.min_tens};
			calendar_pkg::VIEW_MMDD: pick = '{d.day_unit, d.day_tens, d.month_unit, d.month_tens};
			default: pick = '{d.year_unit, d.year_tens, d.year_hund, d.year_thou};
		endcase
		return pick[idx];
	endfunction

	function automatic string date_str(input calendar_pkg::date_time_t d);
		return $sformatf("%h%h%h%h-%h%h-%h%h %h%h:%h%h:%h%h", d.year_thou, d.year_hund,
			d.year_tens, d.year_unit, d.month_tens, d.month_unit, d.day_tens, d.day_unit,
			d.hour_tens, d.hour_unit, d.min_tens, d.min_unit, d.sec_tens, d.sec_unit);
	endfunction

	//////////////////////////////
	// random dates
	//////////////////////////////
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003; // x^32 + x^22 + x^2 + x + 1
		return s >> 1;
	endfunction

	task automatic random_below(input int n, output int v);
		logic [15:0] bits;
		for (int i = 0; i < 16; i++) begin
			lfsr = lfsr_step(lfsr);
			bits = {bits[14:0], lfsr[0]}; // one step per bit
		end
		v = bits % n;
	endtask

	task automatic random_date(output calendar_pkg::date_time_t d);
		int y, mo, dy, h, mi, s;
		random_below(10000, y);
		random_below(12, mo);
		random_below(last_day(mo + 1, y), dy); // day valid for month
		random_below(24, h);
		random_below(60, mi);
		random_below(60, s);
		d = make_date(y, mo + 1, dy + 1, h, mi, s);
	endtask

	//////////////////////////////
	// checks
	//////////////////////////////
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_date(input string name, input calendar_pkg::date_time_t exp_d,
		input calendar_pkg::date_time_t act_d);
		if (act_d !== exp_d)
			abort_run($sformatf("FAIL %s: expected %s, actual %s", name, date_str(exp_d),
				date_str(act_d)));
	endtask

	task automatic check_seg(input string name, input calendar_pkg::ssd_t exp_s,
		input calendar_pkg::ssd_t act_s);
		if (act_s !== exp_s)
			abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp_s, act_s));
	endtask

	task automatic check_scan(input string name, input calendar_pkg::scan_t exp_e,
		input calendar_pkg::scan_t act_e);
		if (act_e !== exp_e)
			abort_run($sformatf("FAIL %s: expected %b, actual %b", name, exp_e, act_e));
	endtask

	task automatic check_bit(input string name, input logic exp_b, input logic act_b);
		if (act_b !== exp_b)
			abort_run($sformatf("FAIL %s: expected %b, actual %b", name, exp_b, act_b));
	endtask

	// monitor of now against the model
	always @(negedge clk) begin
		if (track_mode == TRACK_STEP)
			expected = next_second(expected);
		if (track_mode != TRACK_OFF)
			check_date(track_name, expected, now);
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= LIMIT)
			abort_run($sformatf("timeout: run did not finish within %0d cycles", LIMIT));
	end

	//////////////////////////////
	// stimulus tasks
	//////////////////////////////
	task automatic select_rate(input calendar_pkg::rate_t r);
		@(posedge clk);
		track_mode = TRACK_OFF; // now jumps around a rate change
		rate <= r;
	endtask

	task automatic set_date_handshake(input string name, input calendar_pkg::date_time_t d,
		input int mode_after);
		@(posedge clk);
		track_mode = TRACK_OFF;
		set_in <= '{date: d, req: 1'b1};
		@(posedge clk);
		@(negedge clk);
		check_bit({name, " ack before load"}, 1'b0, set_ack);
		@(posedge clk);
		@(negedge clk);
		check_bit({name, " ack rise"}, 1'b1, set_ack); // two cycles after req
		check_date({name, " loaded date"}, d, now);
		@(posedge clk);
		set_in.req <= 1'b0;
		expected   = d;
		track_name = name;
		track_mode = mode_after;
		@(negedge clk);
		check_bit({name, " ack held"}, 1'b1, set_ack);
		@(posedge clk);
		@(negedge clk);
		check_bit({name, " ack fall"}, 1'b0, set_ack); // one cycle after req drops
	endtask

	task automatic check_display(input calendar_pkg::view_t v);
		calendar_pkg::date_time_t d;
		calendar_pkg::scan_t seen;
		int idx;
		random_date(d);
		@(posedge clk);
		view <= v;
		set_date_handshake("display load", d, TRACK_HOLD);
		seen = '0;
		repeat (4 * `CAL_SCAN_DIV) begin
			@(negedge clk);
			case (digit_en)
				4'b0001: idx = 0;
				4'b0010: idx = 1;
				4'b0100: idx = 2;
				4'b1000: idx = 3;
				default: abort_run($sformatf("digit enable %b is not one-hot", digit_en));
			endcase
			seen = seen | digit_en;
			check_seg($sformatf("display view %0d digit %0d", v, idx),
				seg_table[view_digit(d, v, idx)], seg);
		end
		check_bit("display scan reaches all digits", 1'b1, &seen);
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////
	initial begin
		calendar_pkg::date_time_t start;
		calendar_pkg::date_time_t d;
		int n;
		reset  = 1'b1;
		rate   = calendar_pkg::RATE_SLOW;
		view   = calendar_pkg::VIEW_HHMM;
		set_in = '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		start = make_date(`CAL_RESET_YEAR_THOU * 1000 + `CAL_RESET_YEAR_HUND * 100 +
			`CAL_RESET_YEAR_TENS * 10 + `CAL_RESET_YEAR_UNIT, 1, 1, 0, 0, 0);
		check_date("reset date", start, now);
		check_bit("reset set_ack", 1'b0, set_ack);
		check_scan("reset digit_en", 4'b0001, digit_en);

		// fast rate, one second per divider period
		select_rate(calendar_pkg::RATE_FAST);
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (now === start);
		// rate seen, one full period, then the now register
		if (n != `CAL_DIV_FAST + 3)
			abort_run($sformatf("FAIL tick rate first tick delay: expected %0d, actual %0d",
				`CAL_DIV_FAST + 3, n));
		d = next_second(start);
		check_date("tick rate first tick", d, now);
		repeat (19) begin
			for (int c = 1; c <= `CAL_DIV_FAST; c++) begin
				@(negedge clk);
				if (c == `CAL_DIV_FAST)
					d = next_second(d);
				check_date("tick rate spacing", d, now);
			end
		end

		select_rate(calendar_pkg::RATE_FULL);
		set_date_handshake("rollover year end", make_date(2023, 12, 31, 23, 59, 59), TRACK_STEP);
		repeat (5) @(posedge clk);
		set_date_handshake("rollover leap feb", make_date(2024, 2, 28, 23, 59, 58), TRACK_STEP);
		repeat (5) @(posedge clk);
		set_date_handshake("rollover 1900 feb", make_date(1900, 2, 28, 23, 59, 59), TRACK_STEP);
		repeat (5) @(posedge clk);
		set_date_handshake("rollover 2000 feb", make_date(2000, 2, 28, 23, 59, 59), TRACK_STEP);
		repeat (5) @(posedge clk);
		set_date_handshake("rollover april", make_date(2023, 4, 30, 23, 59, 59), TRACK_STEP);
		repeat (5) @(posedge clk);
		set_date_handshake("rollover 9999", make_date(9999, 12, 31, 23, 59, 59), TRACK_STEP);
		repeat (5) @(posedge clk);

		repeat (40) begin
			random_date(d);
			set_date_handshake("random run", d, TRACK_STEP);
			repeat (50) @(posedge clk);
		end

		select_rate(calendar_pkg::RATE_SLOW); // keeps now still while scanning
		for (int v = 0; v < 4; v++)
			check_display(calendar_pkg::view_t'(v));

		$display("All tests passed");
		$finish;
	end

endmodule

/* calendar_top.f */
+incdir+design
design/calendar_pkg.sv
design/tick_gen.sv
design/date_loader.sv
design/bcd_counter.sv
design/month_length.sv
design/calendar_core.sv
design/display_scan.sv
design/calendar_top.sv
tb/calendar_tb.sv

/* Bender.yml */
package:
  name: calendar_clock

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/calendar_pkg.sv
      - design/tick_gen.sv
      - design/date_loader.sv
      - design/bcd_counter.sv
      - design/month_length.sv
      - design/calendar_core.sv
      - design/display_scan.sv
      - design/calendar_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/calendar_tb.sv
